// File: source/mipsPkg.sv
package mipsPkg;

	//////////////////////////////////////////////////////////////
	// Major opcodes
	//////////////////////////////////////////////////////////////
	localparam logic [5:0] OpSpecial = 6'h00;
	localparam logic [5:0] OpJ       = 6'h02;
	localparam logic [5:0] OpBeq     = 6'h04;
	localparam logic [5:0] OpBne     = 6'h05;
	localparam logic [5:0] OpAddiu   = 6'h09;
	localparam logic [5:0] OpSltiu   = 6'h0b;
	localparam logic [5:0] OpAndi    = 6'h0c;
	localparam logic [5:0] OpOri     = 6'h0d;
	localparam logic [5:0] OpXori    = 6'h0e;
	localparam logic [5:0] OpLui     = 6'h0f;
	localparam logic [5:0] OpLw      = 6'h23;
	localparam logic [5:0] OpSw      = 6'h2b;

	// Funct field of SPECIAL
	localparam logic [5:0] FnSll  = 6'h00;
	localparam logic [5:0] FnSrl  = 6'h02;
	localparam logic [5:0] FnAddu = 6'h21;
	localparam logic [5:0] FnSubu = 6'h23;
	localparam logic [5:0] FnAnd  = 6'h24;
	localparam logic [5:0] FnOr   = 6'h25;
	localparam logic [5:0] FnXor  = 6'h26;
	localparam logic [5:0] FnNor  = 6'h27;
	localparam logic [5:0] FnSlt  = 6'h2a;
	localparam logic [5:0] FnSltu = 6'h2b;

	//////////////////////////////////////////////////////////////
	// ALU operations, written by the decoder
	//////////////////////////////////////////////////////////////
	localparam logic [3:0] AluAdd = 4'd0;
	localparam logic [3:0] AluSub = 4'd1;
	localparam logic [3:0] AluAnd = 4'd2;
	localparam logic [3:0] AluOr  = 4'd3;
	localparam logic [3:0] AluXor = 4'd4;
	localparam logic [3:0] AluNor = 4'd5;
	localparam logic [3:0] AluLt  = 4'd6;
	localparam logic [3:0] AluLtu = 4'd7;
	localparam logic [3:0] AluSll = 4'd8;
	localparam logic [3:0] AluSrl = 4'd9;
	localparam logic [3:0] AluLui = 4'd10;

	localparam logic ExtZero = 1'b0;
	localparam logic ExtSign = 1'b1;

	// J-type target is the low 26 bits of the iType view
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} rType;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} iType;
	} instrWord;

endpackage

// File: source/coreIfs.sv
// One requester's view of the shared memory port
interface memBusIf;
	logic        req;
	logic        we;
	logic [31:0] addr;
	logic [31:0] wdata;
	logic [31:0] rdata;
	logic        ready;

	modport requester (output req, we, addr, wdata, input rdata, ready);
	modport arbiter (input req, we, addr, wdata, output rdata, ready);
endinterface

// Control bundle produced by the main decoder
interface decodeIf;
	logic [3:0] aluOp;
	logic       extOp;
	logic       aluBSel;
	logic       regWe;
	logic       rdIsRt;
	logic       isLoad;
	logic       isStore;
	logic       isBranch;
	logic       isJump;
	logic       illegal;

	modport producer (output aluOp, extOp, aluBSel, regWe, rdIsRt,
		isLoad, isStore, isBranch, isJump, illegal);
	modport consumer (input aluOp, extOp, aluBSel, regWe, rdIsRt,
		isLoad, isStore, isBranch, isJump, illegal);
endinterface

// File: source/mainDecoder.sv
module mainDecoder (
	input  mipsPkg::instrWord instr,
	decodeIf.producer         ctrl
);

	always_comb
	begin
		// All-zero controls unless an encoding below matches
		ctrl.aluOp    = mipsPkg::AluAdd;
		ctrl.extOp    = mipsPkg::ExtZero;
		ctrl.aluBSel  = 1'b0;
		ctrl.regWe    = 1'b0;
		ctrl.rdIsRt   = 1'b0;
		ctrl.isLoad   = 1'b0;
		ctrl.isStore  = 1'b0;
		ctrl.isBranch = 1'b0;
		ctrl.isJump   = 1'b0;
		ctrl.illegal  = 1'b0;

		case (instr.rType.op)
			mipsPkg::OpSpecial:
			begin
				ctrl.regWe = 1'b1;
				case (instr.rType.funct)
					mipsPkg::FnAddu: ctrl.aluOp = mipsPkg::AluAdd;
					mipsPkg::FnSubu: ctrl.aluOp = mipsPkg::AluSub;
					mipsPkg::FnAnd:  ctrl.aluOp = mipsPkg::AluAnd;
					mipsPkg::FnOr:   ctrl.aluOp = mipsPkg::AluOr;
					mipsPkg::FnXor:  ctrl.aluOp = mipsPkg::AluXor;
					mipsPkg::FnNor:  ctrl.aluOp = mipsPkg::AluNor;
					mipsPkg::FnSlt:  ctrl.aluOp = mipsPkg::AluLt;
					mipsPkg::FnSltu: ctrl.aluOp = mipsPkg::AluLtu;
					mipsPkg::FnSll:  ctrl.aluOp = mipsPkg::AluSll;
					mipsPkg::FnSrl:  ctrl.aluOp = mipsPkg::AluSrl;
					default:
					begin
						ctrl.regWe   = 1'b0;
						ctrl.illegal = 1'b1;
					end
				endcase
			end
			mipsPkg::OpAddiu, mipsPkg::OpSltiu, mipsPkg::OpAndi,
			mipsPkg::OpOri, mipsPkg::OpXori, mipsPkg::OpLui, mipsPkg::OpLw:
			begin
				ctrl.regWe   = 1'b1;
				ctrl.rdIsRt  = 1'b1;
				ctrl.aluBSel = 1'b1;
				case (instr.iType.op)
					mipsPkg::OpAndi: ctrl.aluOp = mipsPkg::AluAnd;
					mipsPkg::OpOri:  ctrl.aluOp = mipsPkg::AluOr;
					mipsPkg::OpXori: ctrl.aluOp = mipsPkg::AluXor;
					mipsPkg::OpLui:  ctrl.aluOp = mipsPkg::AluLui;
					mipsPkg::OpSltiu: ctrl.aluOp = mipsPkg::AluLtu;
					default:         ctrl.aluOp = mipsPkg::AluAdd;
				endcase
				// Logic ops and LUI keep zero extension
				ctrl.extOp  = (ctrl.aluOp == mipsPkg::AluAdd || ctrl.aluOp == mipsPkg::AluLtu)
					? mipsPkg::ExtSign : mipsPkg::ExtZero;
				ctrl.isLoad = (instr.iType.op == mipsPkg::OpLw);
			end
			mipsPkg::OpSw:
			begin
				ctrl.aluBSel = 1'b1;
				ctrl.extOp   = mipsPkg::ExtSign;
				ctrl.isStore = 1'b1;
			end
			mipsPkg::OpBeq, mipsPkg::OpBne:
			begin
				ctrl.aluOp    = mipsPkg::AluSub;
				ctrl.isBranch = 1'b1;
			end
			mipsPkg::OpJ:
				ctrl.isJump = 1'b1;
			default:
				ctrl.illegal = 1'b1;
		endcase
	end

endmodule

// File: source/aluUnit.sv
module aluUnit (
	input  logic [3:0]  op,
	input  logic [31:0] a,
	input  logic [31:0] b,
	input  logic [4:0]  shamt,
	output logic [31:0] result,
	output logic        zero
);

	always_comb
	begin
		case (op)
			mipsPkg::AluAdd: result = a + b;
			mipsPkg::AluSub: result = a - b;
			mipsPkg::AluAnd: result = a & b;
			mipsPkg::AluOr:  result = a | b;
			mipsPkg::AluXor: result = a ^ b;
			mipsPkg::AluNor: result = ~(a | b);
			mipsPkg::AluLt:  result = {31'b0, $signed(a) < $signed(b)};
			mipsPkg::AluLtu: result = {31'b0, a < b};
			// Shifts move the rt operand
			mipsPkg::AluSll: result = b << shamt;
			mipsPkg::AluSrl: result = b >> shamt;
			mipsPkg::AluLui: result = {b[15:0], 16'b0};
			default:         result = 32'b0;
		endcase
	end

	// Branch compare uses the subtract result
	assign zero = (result == 32'b0);

endmodule

// File: source/regFile.sv
module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [4:0]  raddrA,
	input  logic [4:0]  raddrB,
	output logic [31:0] rdataA,
	output logic [31:0] rdataB,
	input  logic        we,
	input  logic [4:0]  waddr,
	input  logic [31:0] wdata
);

	logic [31:0] regs [32];

	// Register 0 is never written, so it stays zero after reset
	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'b0;
		else if (we && waddr != 5'd0)
			regs[waddr] <= wdata;
	end

	assign rdataA = regs[raddrA];
	assign rdataB = regs[raddrB];

endmodule

// File: source/instrSequencer.sv
module instrSequencer #(
	parameter logic [31:0] ResetPc = 32'h0
) (
	input  logic              clk,
	input  logic              arstN,
	memBusIf.requester        bus,
	decodeIf.consumer         ctrl,
	output mipsPkg::instrWord instr,
	input  logic              branchTaken,
	input  logic [31:0]       target,
	input  logic              memDone,
	output logic              memPhase,
	output logic              regWe,
	output logic              halted
);

	localparam logic [2:0] Fetch     = 3'd0;
	localparam logic [2:0] Execute   = 3'd1;
	localparam logic [2:0] Memory    = 3'd2;
	localparam logic [2:0] Writeback = 3'd3;
	localparam logic [2:0] Halt      = 3'd4;

	logic [2:0]  state;
	logic [31:0] pc, pcNext4, redirectPc, pfAddr, pfData;
	logic        pfBusy, pfValid, pfDrop, fetchHit, take, redirect, started;

	assign pcNext4    = pc + 32'd4;
	// Jump keeps the 256 MB region; branch offset is relative to pc + 4
	assign redirectPc = ctrl.isJump ? {pcNext4[31:28], target[27:0]} : pcNext4 + target;
	assign redirect   = branchTaken || ctrl.isJump;

	// Outstanding prefetch has priority over a fresh fetch of pc
	// First fetch goes out after the first clock edge past reset
	assign bus.req   = pfBusy || (state == Fetch && !pfValid && started);
	assign bus.addr  = pfBusy ? pfAddr : pc;
	assign bus.we    = 1'b0;
	assign bus.wdata = 32'b0;

	assign fetchHit = bus.ready && !pfDrop;
	assign take     = (state == Fetch) && (pfValid || fetchHit);
	assign memPhase = (state == Memory);
	assign regWe    = (state == Writeback) && ctrl.regWe;
	assign halted   = (state == Halt);

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			state   <= Fetch;
			pc      <= ResetPc;
			pfBusy  <= 1'b0;
			pfValid <= 1'b0;
			pfDrop  <= 1'b0;
			started <= 1'b0;
		end
		else
		begin
			started <= 1'b1;
			if (pfBusy && bus.ready)
			begin
				pfBusy  <= 1'b0;
				pfDrop  <= 1'b0;
				pfValid <= !pfDrop;
			end
			case (state)
				Fetch:
					if (take)
					begin
						// Next sequential word goes out on entry to Execute
						pfValid <= 1'b0;
						pfBusy  <= 1'b1;
						state   <= Execute;
					end
				Execute:
					if (ctrl.illegal)
						state <= Halt;
					else
					begin
						pc <= redirect ? redirectPc : pcNext4;
						if (redirect)
						begin
							pfValid <= 1'b0;
							pfDrop  <= pfBusy && !bus.ready;
						end
						state <= (ctrl.isLoad || ctrl.isStore) ? Memory : Writeback;
					end
				Memory:
					if (memDone)
						state <= Writeback;
				Writeback:
					state <= Fetch;
				default:
					state <= Halt;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Instruction and prefetch words
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (bus.ready)
			pfData <= bus.rdata;
		if (take)
		begin
			instr  <= pfValid ? pfData : bus.rdata;
			pfAddr <= pcNext4;
		end
	end

endmodule

// File: source/loadStoreUnit.sv
module loadStoreUnit (
	input  logic        clk,
	input  logic        arstN,
	memBusIf.requester  bus,
	decodeIf.consumer   ctrl,
	input  logic        start,
	input  logic [31:0] addr,
	input  logic [31:0] storeData,
	output logic        done,
	output logic [31:0] loadData
);

	// Request stays up for the whole Memory state
	assign bus.req   = start;
	assign bus.we    = start && ctrl.isStore;
	assign bus.addr  = addr;
	assign bus.wdata = storeData;
	assign done      = start && bus.ready;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			loadData <= 32'b0;
		else if (done && ctrl.isLoad)
			loadData <= bus.rdata;
	end

endmodule

// File: source/memArbiter.sv
module memArbiter (
	input  logic        clk,
	input  logic        arstN,
	memBusIf.arbiter    fetch,
	memBusIf.arbiter    data,
	output logic        memReq,
	output logic        memWe,
	output logic [31:0] memAddr,
	output logic [31:0] memWdata,
	input  logic [31:0] memRdata,
	input  logic        memReady
);

	logic locked, owner, grantData;

	// Data side wins a tie; an open transfer keeps its owner
	assign grantData = locked ? owner : data.req;

	assign memReq   = grantData ? data.req : fetch.req;
	assign memWe    = grantData ? data.we : fetch.we;
	assign memAddr  = grantData ? data.addr : fetch.addr;
	assign memWdata = grantData ? data.wdata : fetch.wdata;

	assign data.ready  = grantData && memReady;
	assign fetch.ready = !grantData && memReady;
	assign data.rdata  = grantData ? memRdata : 32'b0;
	assign fetch.rdata = grantData ? 32'b0 : memRdata;

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			locked <= 1'b0;
			owner  <= 1'b0;
		end
		else if (memReady)
			locked <= 1'b0;
		else if (memReq)
		begin
			locked <= 1'b1;
			owner  <= grantData;
		end
	end

endmodule

// File: source/mipsCore.sv
module mipsCore #(
	parameter logic [31:0] ResetPc = 32'h0
) (
	input  logic        clk,
	input  logic        arstN,
	output logic        memReq,
	output logic        memWe,
	output logic [31:0] memAddr,
	output logic [31:0] memWdata,
	input  logic [31:0] memRdata,
	input  logic        memReady,
	output logic        trap
);

	memBusIf fetchBus ();
	memBusIf dataBus ();
	decodeIf ctrl ();

	mipsPkg::instrWord instr;
	logic [31:0] rdataA, rdataB, extImm, aluB, aluResult, target, loadData, wbData;
	logic [4:0]  waddr;
	logic        zero, branchTaken, memPhase, memDone, regWe, halted;

	//////////////////////////////////////////////////////////////
	// Operands, targets and writeback
	//////////////////////////////////////////////////////////////
	assign extImm = (ctrl.extOp == mipsPkg::ExtSign)
		? {{16{instr.iType.imm[15]}}, instr.iType.imm} : {16'b0, instr.iType.imm};
	assign aluB   = ctrl.aluBSel ? extImm : rdataB;

	// BNE inverts the equality test
	assign branchTaken = ctrl.isBranch && (zero ^ (instr.iType.op == mipsPkg::OpBne));
	assign target = ctrl.isJump
		? {4'b0, instr.iType.rs, instr.iType.rt, instr.iType.imm, 2'b00}
		: {{14{instr.iType.imm[15]}}, instr.iType.imm, 2'b00};

	assign waddr  = ctrl.rdIsRt ? instr.iType.rt : instr.rType.rd;
	assign wbData = ctrl.isLoad ? loadData : aluResult;
	assign trap   = halted;

	mainDecoder uDecoder (.instr(instr), .ctrl(ctrl));

	regFile uRegs (.clk(clk), .arstN(arstN), .raddrA(instr.rType.rs), .raddrB(instr.rType.rt),
		.rdataA(rdataA), .rdataB(rdataB), .we(regWe), .waddr(waddr), .wdata(wbData));

	aluUnit uAlu (.op(ctrl.aluOp), .a(rdataA), .b(aluB), .shamt(instr.rType.shamt),
		.result(aluResult), .zero(zero));

	instrSequencer #(.ResetPc(ResetPc)) uSeq (.clk(clk), .arstN(arstN), .bus(fetchBus),
		.ctrl(ctrl), .instr(instr), .branchTaken(branchTaken), .target(target),
		.memDone(memDone), .memPhase(memPhase), .regWe(regWe), .halted(halted));

	loadStoreUnit uLsu (.clk(clk), .arstN(arstN), .bus(dataBus), .ctrl(ctrl),
		.start(memPhase), .addr(aluResult), .storeData(rdataB), .done(memDone),
		.loadData(loadData));

	memArbiter uArb (.clk(clk), .arstN(arstN), .fetch(fetchBus), .data(dataBus),
		.memReq(memReq), .memWe(memWe), .memAddr(memAddr), .memWdata(memWdata),
		.memRdata(memRdata), .memReady(memReady));

endmodule

// File: testbench/tbClock.sv
module tbClock (
	output logic clk,
	output logic arstN
);
	timeunit 1ns;
	timeprecision 100ps;

	// 8 ns period, reset held for two rising edges
	initial
	begin
		clk   = 1'b0;
		arstN = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
	end

	always #4 clk = ~clk;

endmodule

// File: testbench/tbMipsCore.sv
module tbMipsCore;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] ResetPc = 32'h0;
	localparam logic [31:0] Seed    = 32'hcb1a_ed27;
	localparam int TestReset = 0;
	localparam int TestAlu   = 1;
	localparam int TestLdSt  = 2;
	localparam int TestCtrl  = 3;
	localparam int TestArb   = 4;
	localparam int TestIll   = 5;

	logic        clk, arstN, memReq, memWe, memReady, trap, runMem, busy;
	logic [31:0] memAddr, memWdata, memRdata;
	logic [31:0] mem [256];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] gotAddr [$];
	logic [31:0] gotData [$];
	int          expTest [$];
	int          errs [6] = '{default: 0};
	string       names [6] = '{"reset", "alu", "loadStore", "controlFlow", "arbitration",
		"illegal"};
	int          delay, slot, passed;
	logic [31:0] storeAddr;

	tbClock uClock (.clk(clk), .arstN(arstN));

	mipsCore #(.ResetPc(ResetPc)) UUT (.clk(clk), .arstN(arstN), .memReq(memReq),
		.memWe(memWe), .memAddr(memAddr), .memWdata(memWdata), .memRdata(memRdata),
		.memReady(memReady), .trap(trap));

	//////////////////////////////////////////////////////////////
	// Program image helpers
	//////////////////////////////////////////////////////////////
	function automatic logic [31:0] rWord(input logic [5:0] funct, input int rs, input int rt,
		input int rd, input int sh);
		return {mipsPkg::OpSpecial, 5'(rs), 5'(rt), 5'(rd), 5'(sh), funct};
	endfunction

	function automatic logic [31:0] iWord(input logic [5:0] op, input int rs, input int rt,
		input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] jumpTo(input int wordIdx);
		return {mipsPkg::OpJ, 26'(wordIdx)};
	endfunction

	task automatic emit(input logic [31:0] word);
		mem[slot] = word;
		slot++;
	endtask

	// Instruction followed by a SW of its result to the next result slot
	task automatic emitAndStore(input logic [31:0] word, input int rd, input logic [31:0] value,
		input int test);
		emit(word);
		emit(iWord(mipsPkg::OpSw, 0, rd, storeAddr[15:0]));
		expAddr.push_back(storeAddr);
		expData.push_back(value);
		expTest.push_back(test);
		storeAddr += 32'd4;
	endtask

	task automatic recordWrite(input logic [31:0] addr, input logic [31:0] data);
		assert (addr >= 32'h100)
		else
		begin
			errs[TestLdSt]++;
			$display("loadStore: a write hit instruction address %h", addr);
		end
		assert (addr < 32'h300)
		else
		begin
			errs[TestCtrl]++;
			$display("controlFlow: a store on a skipped path reached address %h", addr);
		end
		mem[addr[9:2]] = data;
		gotAddr.push_back(addr);
		gotData.push_back(data);
	endtask

	task automatic reportTest(input int id);
		if (errs[id] == 0)
			$display("Test %s passed", names[id]);
		else
			$display("Test %s failed with %0d errors", names[id], errs[id]);
	endtask

	//////////////////////////////////////////////////////////////
	// Memory model with 0 to 3 cycles of latency
	//////////////////////////////////////////////////////////////
	always @(posedge clk)
		runMem <= arstN;

	initial
	begin
		memReady = 1'b0;
		memRdata = 32'b0;
		busy     = 1'b0;
		delay    = 0;
		void'($urandom(Seed));
		forever
		begin
			@(negedge clk);
			memReady = 1'b0;
			if (runMem && memReq)
			begin
				if (!busy)
				begin
					busy  = 1'b1;
					delay = $urandom % 4;
				end
				if (delay == 0)
				begin
					busy     = 1'b0;
					memReady = 1'b1;
					memRdata = mem[memAddr[9:2]];
					if (memWe)
						recordWrite(memAddr, memWdata);
				end
				else
					delay--;
			end
		end
	end

	// Request must hold until the memory answers
	property requestHeld;
		@(posedge clk) disable iff (!arstN)
			memReq && !memReady |=> memReq && $stable(memAddr) && $stable(memWe);
	endproperty

	holdCheck: assert property (requestHeld)
	else
	begin
		errs[TestArb]++;
		$display("arbitration: the memory request changed before memReady at %0t", $time);
	end

	trapCheck: assert property (@(posedge clk) disable iff (!arstN) trap |=> trap)
	else
	begin
		errs[TestIll]++;
		$display("illegal: trap fell while reset was released at %0t", $time);
	end

	initial
	begin
		logic [31:0] a, b, preset;
		bit ok;
		int n;

		for (n = 0; n < 256; n++)
			mem[n] = 32'hc0de_0000 | (n << 2);
		a         = 32'hffff_fff9;
		b         = 32'd5;
		preset    = 32'h1234_5678;
		mem[64]   = preset;
		slot      = ResetPc[9:2];
		storeAddr = 32'h200;
		passed    = 0;

		// ALU and immediate ops with operands a = -7 and b = 5
		emitAndStore(iWord(mipsPkg::OpAddiu, 0, 1, 16'hfff9), 1, a, TestAlu);
		emitAndStore(iWord(mipsPkg::OpAddiu, 0, 2, 16'h0005), 2, b, TestAlu);
		emitAndStore(rWord(mipsPkg::FnAddu, 1, 2, 3, 0), 3, a + b, TestAlu);
		emitAndStore(rWord(mipsPkg::FnSubu, 2, 1, 4, 0), 4, b - a, TestAlu);
		emitAndStore(rWord(mipsPkg::FnAnd, 1, 2, 5, 0), 5, a & b, TestAlu);
		emitAndStore(rWord(mipsPkg::FnOr, 1, 2, 6, 0), 6, a | b, TestAlu);
		emitAndStore(rWord(mipsPkg::FnXor, 1, 2, 7, 0), 7, a ^ b, TestAlu);
		emitAndStore(rWord(mipsPkg::FnNor, 1, 2, 8, 0), 8, ~(a | b), TestAlu);
		emitAndStore(rWord(mipsPkg::FnSlt, 1, 2, 9, 0), 9,
			($signed(a) < $signed(b)) ? 32'd1 : 32'd0, TestAlu);
		emitAndStore(rWord(mipsPkg::FnSltu, 1, 2, 10, 0), 10, (a < b) ? 32'd1 : 32'd0, TestAlu);
		emitAndStore(rWord(mipsPkg::FnSltu, 2, 1, 11, 0), 11, (b < a) ? 32'd1 : 32'd0, TestAlu);
		emitAndStore(rWord(mipsPkg::FnSll, 0, 1, 12, 4), 12, a << 4, TestAlu);
		emitAndStore(rWord(mipsPkg::FnSrl, 0, 1, 13, 3), 13, a >> 3, TestAlu);
		// SLTIU compares against the sign-extended immediate
		emitAndStore(iWord(mipsPkg::OpSltiu, 2, 14, 16'hffff), 14,
			(b < 32'hffff_ffff) ? 32'd1 : 32'd0, TestAlu);
		emitAndStore(iWord(mipsPkg::OpAndi, 1, 15, 16'h8f0f), 15, a & 32'h0000_8f0f, TestAlu);
		emitAndStore(iWord(mipsPkg::OpOri, 2, 16, 16'h8000), 16, b | 32'h0000_8000, TestAlu);
		emitAndStore(iWord(mipsPkg::OpXori, 1, 17, 16'h8001), 17, a ^ 32'h0000_8001, TestAlu);
		emitAndStore(iWord(mipsPkg::OpLui, 0, 18, 16'h8765), 18, 32'h8765_0000, TestAlu);

		// Load, modify, store back
		emit(iWord(mipsPkg::OpLw, 0, 19, 16'h0100));
		emitAndStore(iWord(mipsPkg::OpAddiu, 19, 20, 16'h0011), 20, preset + 32'h11, TestLdSt);

		// Taken BEQ skips two stores, BNE falls through, J skips one store
		emit(iWord(mipsPkg::OpBeq, 2, 2, 16'd2));
		emit(iWord(mipsPkg::OpSw, 0, 1, 16'h0300));
		emit(iWord(mipsPkg::OpSw, 0, 1, 16'h0304));
		emit(iWord(mipsPkg::OpBne, 2, 2, 16'd1));
		emitAndStore(iWord(mipsPkg::OpAddiu, 0, 21, 16'h0021), 21, 32'h21, TestCtrl);
		emit(jumpTo(slot + 2));
		emit(iWord(mipsPkg::OpSw, 0, 1, 16'h0308));
		emitAndStore(iWord(mipsPkg::OpAddiu, 0, 22, 16'h0022), 22, 32'h22, TestCtrl);
		// Opcode 0x3f is undefined
		emit(32'hfc00_0000);

		//////////////////////////////////////////////////////////
		// Reset and first fetch
		//////////////////////////////////////////////////////////
		ok = 1'b0;
		for (n = 0; n < 10 && !ok; n++)
		begin
			@(negedge clk);
			#1;
			ok = arstN;
			assert (!memReq && !memWe && !trap)
			else
			begin
				errs[TestReset]++;
				$display("reset: memReq, memWe or trap is high around reset");
			end
		end
		if (!ok)
		begin
			errs[TestReset]++;
			$display("reset: arstN was never released");
		end

		// First request follows within a few cycles
		ok = 1'b0;
		for (n = 0; n < 10 && !ok; n++)
		begin
			@(negedge clk);
			#1;
			ok = memReq;
		end
		if (!ok)
		begin
			errs[TestReset]++;
			$display("reset: no request followed the release of reset");
		end
		else
		begin
			assert (!memWe)
			else
			begin
				errs[TestReset]++;
				$display("reset: the first request after reset is a write");
			end
			assert (memAddr == ResetPc)
			else
			begin
				errs[TestReset]++;
				$display("[ERROR] reset: expected %h, actual %h", ResetPc, memAddr);
			end
		end
		reportTest(TestReset);

		// Run the program until the illegal opcode traps
		ok = 1'b0;
		for (n = 0; n < 3000 && !ok; n++)
		begin
			@(negedge clk);
			#1;
			ok = trap;
		end
		if (!ok)
		begin
			errs[TestIll]++;
			$display("illegal: trap did not rise within 3000 cycles");
		end

		for (n = 0; n < expAddr.size() && n < gotAddr.size(); n++)
			assert (gotAddr[n] == expAddr[n] && gotData[n] == expData[n])
			else
			begin
				errs[expTest[n]]++;
				$display("[ERROR] %s: expected %h at %h, actual %h at %h", names[expTest[n]],
					expData[n], expAddr[n], gotData[n], gotAddr[n]);
			end
		assert (gotAddr.size() == expAddr.size())
		else
		begin
			errs[TestArb]++;
			$display("arbitration: %0d stores were expected but %0d arrived", expAddr.size(),
				gotAddr.size());
		end
		reportTest(TestAlu);
		reportTest(TestLdSt);
		reportTest(TestCtrl);
		reportTest(TestArb);

		// An outstanding prefetch may still finish, then the bus stays quiet
		ok = 1'b0;
		for (n = 0; n < 10 && !ok; n++)
		begin
			@(negedge clk);
			#1;
			ok = !memReq;
		end
		if (!ok)
		begin
			errs[TestIll]++;
			$display("illegal: the memory request did not drop after the trap");
		end
		for (n = 0; n < 16; n++)
		begin
			@(negedge clk);
			#1;
			assert (!memReq && trap)
			else
			begin
				errs[TestIll]++;
				$display("illegal: a new request started or trap fell after halting");
			end
		end
		reportTest(TestIll);

		for (n = 0; n < 6; n++)
			if (errs[n] == 0)
				passed++;
		$display("Tests run: 6, passed: %0d, failed: %0d", passed, 6 - passed);
		if (passed == 6)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: list.f
source/mipsPkg.sv
source/coreIfs.sv
source/mainDecoder.sv
source/aluUnit.sv
source/regFile.sv
source/instrSequencer.sv
source/loadStoreUnit.sv
source/memArbiter.sv
source/mipsCore.sv
testbench/tbClock.sv
testbench/tbMipsCore.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - source/mipsPkg.sv
  - source/coreIfs.sv
  - source/mainDecoder.sv
  - source/aluUnit.sv
  - source/regFile.sv
  - source/instrSequencer.sv
  - source/loadStoreUnit.sv
  - source/memArbiter.sv
  - source/mipsCore.sv
  - target: test
    files:
      - testbench/tbClock.sv
      - testbench/tbMipsCore.sv
